// ==== hw/txPkg.sv ====
package txPkg;

	// channel and memory geometry
	localparam int numChannels    = 8;
	localparam int instrWidth     = 64;
	localparam int instrAddrWidth = 13;
	localparam int phaseAddrWidth = 12;
	localparam int phaseWidth     = 16; // per channel, channel 0 in the low bits
	localparam int chargeWidth    = 9;
	localparam int defaultChargeTime = 500;
	localparam int numLoops       = 4;
	localparam int loopCountWidth = 28;
	localparam int trigWidth      = 4;
	localparam int ledWidth       = 2;

	// instruction word fields
	localparam int opHi   = 51;
	localparam int opLo   = 48;
	localparam int argHi  = 47;
	localparam int argLo  = 32;
	localparam int waitHi = 31;
	localparam int waitLo = 0;

	// sub fields of the argument
	localparam int chargeHi = 8;
	localparam int chargeLo = 0;
	localparam int trigHi   = 12;
	localparam int trigLo   = 9;
	localparam int ledHi    = 14;
	localparam int ledLo    = 13;

	// loop ops reuse the wait count field
	localparam int loopIdxHi = 29;
	localparam int loopIdxLo = 28;
	localparam int loopCntHi = 27;
	localparam int loopCntLo = 0;

	typedef enum logic [3:0] {
		opNop           = 4'd0,
		opSetTrig       = 4'd1,
		opSetLeds       = 4'd2,
		opLoopStart     = 4'd4,
		opLoopEnd       = 4'd5,
		opFire          = 4'd6,
		opSetChargeTime = 4'd8,
		opProgramEnd    = 4'd15
	} opcodeT;

	typedef enum logic [1:0] {stIdle, stRun, stDrain} runStateT;

endpackage

// ==== hw/instrFetch.sv ====
`timescale 1ns/1ps

module instrFetch import txPkg::*; (
	input  logic                      txCLK,
	input  logic                      arstN,
	input  logic                      start,
	input  logic                      halt,
	input  logic                      programEnd,
	input  logic                      jumpValid,
	input  logic [instrAddrWidth-1:0] jumpAddr,
	input  logic [instrWidth-1:0]     memData,
	input  logic                      instrReady,
	input  logic                      pulseBusy,
	output logic [instrAddrWidth-1:0] memAddr,
	output logic                      instrValid,
	output logic [instrWidth-1:0]     instrData,
	output logic                      running
);

	runStateT state;
	logic [instrAddrWidth-1:0] addr;
	logic bufValid;
	logic [instrWidth-1:0] bufData;
	logic bufLoad;

	assign memAddr    = addr;
	assign instrValid = bufValid;
	assign instrData  = bufData;
	assign running    = (state != stIdle);

	// refill whenever the buffer is empty or being taken this cycle
	assign bufLoad = (state == stRun) && (!bufValid || (bufValid && instrReady));

	always_ff @(posedge txCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			state    <= stIdle;
			addr     <= '0;
			bufValid <= 1'b0;
		end
		else if (halt)
		begin
			state    <= stIdle;
			bufValid <= 1'b0;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					bufValid <= 1'b0;
					if (start)
					begin
						state <= stRun;
						addr  <= '0; // programs always begin at word 0
					end
				end
				stRun:
				begin
					if (programEnd)
					begin
						state    <= stDrain;
						bufValid <= 1'b0; // prefetched word past the end is dropped
					end
					else if (jumpValid)
					begin
						addr     <= jumpAddr;
						bufValid <= 1'b0;
					end
					else if (bufLoad)
					begin
						bufValid <= 1'b1;
						addr     <= addr + 1'b1;
					end
				end
				stDrain:
				begin
					bufValid <= 1'b0;
					if (!pulseBusy)
						state <= stIdle; // last pulse group has finished
				end
				default: state <= stIdle;
			endcase
		end
	end

	// buffered word, control above decides when it counts
	always_ff @(posedge txCLK)
	begin
		if (bufLoad && !jumpValid && !programEnd)
			bufData <= memData;
	end

endmodule

// ==== hw/instrExecute.sv ====
`timescale 1ns/1ps

module instrExecute import txPkg::*; (
	input  logic                              txCLK,
	input  logic                              arstN,
	input  logic                              halt,
	input  logic                              instrValid,
	input  logic [instrWidth-1:0]             instrData,
	input  logic                              fireReady,
	input  logic [numChannels*phaseWidth-1:0] phaseData,
	output logic                              instrReady,
	output logic                              jumpValid,
	output logic [instrAddrWidth-1:0]         jumpAddr,
	output logic                              programEnd,
	output logic [phaseAddrWidth-1:0]         phaseAddr,
	output logic                              fireValid,
	output logic [numChannels*phaseWidth-1:0] firePhase,
	output logic [chargeWidth-1:0]            fireCharge,
	output logic [trigWidth-1:0]              trigOut,
	output logic [ledWidth-1:0]               ledOut
);

	opcodeT op;
	logic [argHi-argLo:0] arg;
	logic [waitHi-waitLo:0] waitField;
	logic [loopIdxHi-loopIdxLo:0] loopIdx;
	logic [loopCntHi-loopCntLo:0] loopCount;
	logic [loopCountWidth-1:0] loopCnt [numLoops];
	logic [waitHi-waitLo:0] waitCnt;
	logic [waitHi-waitLo:0] fireWait;
	logic [chargeWidth-1:0] chargeTime;
	logic phaseLoad;
	logic xfer;
	logic fireAccept;
	logic loopAgain;

	assign op        = opcodeT'(instrData[opHi:opLo]);
	assign arg       = instrData[argHi:argLo];
	assign waitField = instrData[waitHi:waitLo];
	assign loopIdx   = waitField[loopIdxHi:loopIdxLo];
	assign loopCount = waitField[loopCntHi:loopCntLo];

	// busy while waiting, loading the phase word or holding a fire request
	assign instrReady = (waitCnt == '0) && !phaseLoad && !fireValid;
	assign xfer       = instrValid && instrReady;
	assign fireAccept = fireValid && fireReady;

	// counter starts at 1 so a count of N gives N passes
	assign loopAgain = (loopCnt[loopIdx] < loopCount);

	// redirect and end are taken in the handshake cycle itself
	assign jumpValid  = xfer && (op == opLoopEnd) && loopAgain;
	assign jumpAddr   = arg[instrAddrWidth-1:0]; // first word of the loop body
	assign programEnd = xfer && (op == opProgramEnd);

	always_ff @(posedge txCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			trigOut    <= '0;
			ledOut     <= '0;
			chargeTime <= chargeWidth'(defaultChargeTime);
			waitCnt    <= '0;
			phaseLoad  <= 1'b0;
			fireValid  <= 1'b0;
			phaseAddr  <= '0;
			for (int i = 0; i < numLoops; i++)
				loopCnt[i] <= '0;
		end
		else if (halt)
		begin
			trigOut   <= '0;
			ledOut    <= '0;
			waitCnt   <= '0;
			phaseLoad <= 1'b0;
			fireValid <= 1'b0; // an unaccepted request is dropped
			for (int i = 0; i < numLoops; i++)
				loopCnt[i] <= '0;
		end
		else
		begin
			// phase word is valid one cycle after the address goes out
			if (phaseLoad)
			begin
				phaseLoad <= 1'b0;
				fireValid <= 1'b1;
			end

			if (fireAccept)
			begin
				fireValid <= 1'b0;
				waitCnt   <= fireWait; // fire wait starts at acceptance
			end
			else if (xfer)
			begin
				case (op)
					opSetTrig:
					begin
						trigOut <= arg[trigHi:trigLo];
						waitCnt <= waitField;
					end
					opSetLeds:
					begin
						ledOut  <= arg[ledHi:ledLo];
						waitCnt <= waitField;
					end
					opSetChargeTime:
					begin
						chargeTime <= arg[chargeHi:chargeLo];
						waitCnt    <= waitField;
					end
					opFire:
					begin
						phaseAddr <= arg[phaseAddrWidth-1:0];
						phaseLoad <= 1'b1;
					end
					opLoopStart: loopCnt[loopIdx] <= loopCountWidth'(1);
					opLoopEnd:
					begin
						if (loopAgain)
							loopCnt[loopIdx] <= loopCnt[loopIdx] + 1'b1;
					end
					opProgramEnd: waitCnt <= '0;
					default: waitCnt <= waitField; // unknown opcodes only wait
				endcase
			end
			else if (waitCnt != '0)
				waitCnt <= waitCnt - 1'b1;
		end
	end

	// fire payload, held steady by fireValid
	always_ff @(posedge txCLK)
	begin
		if (xfer && (op == opFire))
		begin
			fireWait   <= waitField;
			fireCharge <= chargeTime;
		end
		if (phaseLoad)
			firePhase <= phaseData;
	end

endmodule

// ==== hw/pulseBank.sv ====
`timescale 1ns/1ps

module pulseBank import txPkg::*; (
	input  logic                              txCLK,
	input  logic                              arstN,
	input  logic                              halt,
	input  logic                              fireValid,
	input  logic [numChannels*phaseWidth-1:0] firePhase,
	input  logic [chargeWidth-1:0]            fireCharge,
	input  logic [numChannels-1:0]            chanMask,
	output logic                              fireReady,
	output logic                              pulseBusy,
	output logic [numChannels-1:0]            txOut
);

	logic busy;
	logic [phaseWidth:0] cnt; // one bit wider than a delay
	logic [phaseWidth:0] endMax;
	logic [phaseWidth-1:0] maxDelay;
	logic [phaseWidth-1:0] delayReg [numChannels];
	logic [chargeWidth-1:0] chargeReg;
	logic [numChannels-1:0] txReg;
	logic accept;

	assign fireReady = !busy;
	assign pulseBusy = busy;
	assign accept    = fireValid && !busy;
	assign txOut     = txReg & chanMask;

	// latest start among the incoming delays
	always_comb
	begin
		maxDelay = '0;
		for (int c = 0; c < numChannels; c++)
			if (firePhase[c*phaseWidth +: phaseWidth] > maxDelay)
				maxDelay = firePhase[c*phaseWidth +: phaseWidth];
	end

	always_ff @(posedge txCLK or negedge arstN)
	begin
		if (!arstN)
			busy <= 1'b0;
		else if (halt)
			busy <= 1'b0;
		else if (accept)
		begin
			busy   <= 1'b1;
			cnt    <= '0;
			endMax <= {1'b0, maxDelay} + (phaseWidth+1)'(fireCharge);
		end
		else if (busy)
		begin
			if (cnt == endMax)
				busy <= 1'b0; // every channel has dropped by now
			else
				cnt <= cnt + 1'b1;
		end
	end

	// delays and charge time captured with the request
	always_ff @(posedge txCLK)
	begin
		if (accept)
		begin
			chargeReg <= fireCharge;
			for (int c = 0; c < numChannels; c++)
				delayReg[c] <= firePhase[c*phaseWidth +: phaseWidth];
		end
	end

	for (genvar c = 0; c < numChannels; c++)
	begin : genChan
		logic [phaseWidth:0] chanEnd;

		assign chanEnd = {1'b0, delayReg[c]} + (phaseWidth+1)'(chargeReg);

		always_ff @(posedge txCLK or negedge arstN)
		begin
			if (!arstN)
				txReg[c] <= 1'b0;
			else if (halt)
				txReg[c] <= 1'b0;
			else
				txReg[c] <= busy && (cnt >= {1'b0, delayReg[c]}) && (cnt < chanEnd);
		end
	end

endmodule

// ==== hw/txSequencer.sv ====
`timescale 1ns/1ps

module txSequencer import txPkg::*; (
	input  logic                              txCLK,
	input  logic                              arstN,
	input  logic                              start,
	input  logic                              halt,
	input  logic [numChannels-1:0]            chanMask,
	input  logic [instrWidth-1:0]             instrData,
	input  logic [numChannels*phaseWidth-1:0] phaseData,
	output logic [instrAddrWidth-1:0]         instrAddr,
	output logic [phaseAddrWidth-1:0]         phaseAddr,
	output logic [numChannels-1:0]            txOut,
	output logic [trigWidth-1:0]              trigOut,
	output logic [ledWidth-1:0]               ledOut,
	output logic                              running
);

	// fetch to execute
	logic instrValid;
	logic instrReady;
	logic [instrWidth-1:0] bufInstr;

	// redirect and end back to fetch
	logic jumpValid;
	logic [instrAddrWidth-1:0] jumpAddr;
	logic programEnd;

	// execute to pulse bank
	logic fireValid;
	logic fireReady;
	logic [numChannels*phaseWidth-1:0] firePhase;
	logic [chargeWidth-1:0] fireCharge;
	logic pulseBusy;

	instrFetch uFetch (
		.txCLK      (txCLK),
		.arstN      (arstN),
		.start      (start),
		.halt       (halt),
		.programEnd (programEnd),
		.jumpValid  (jumpValid),
		.jumpAddr   (jumpAddr),
		.memData    (instrData),
		.instrReady (instrReady),
		.pulseBusy  (pulseBusy),
		.memAddr    (instrAddr),
		.instrValid (instrValid),
		.instrData  (bufInstr),
		.running    (running)
	);

	instrExecute uExecute (
		.txCLK      (txCLK),
		.arstN      (arstN),
		.halt       (halt),
		.instrValid (instrValid),
		.instrData  (bufInstr),
		.fireReady  (fireReady),
		.phaseData  (phaseData),
		.instrReady (instrReady),
		.jumpValid  (jumpValid),
		.jumpAddr   (jumpAddr),
		.programEnd (programEnd),
		.phaseAddr  (phaseAddr),
		.fireValid  (fireValid),
		.firePhase  (firePhase),
		.fireCharge (fireCharge),
		.trigOut    (trigOut),
		.ledOut     (ledOut)
	);

	pulseBank uPulse (
		.txCLK      (txCLK),
		.arstN      (arstN),
		.halt       (halt),
		.fireValid  (fireValid),
		.firePhase  (firePhase),
		.fireCharge (fireCharge),
		.chanMask   (chanMask),
		.fireReady  (fireReady),
		.pulseBusy  (pulseBusy),
		.txOut      (txOut)
	);

endmodule

// ==== sim/txSequencer_assert.sv ====
`timescale 1ns/1ps

module txSequencer_assert import txPkg::*; (
	input logic                              txCLK,
	input logic                              arstN,
	input logic                              halt,
	input logic [numChannels-1:0]            chanMask,
	input logic [numChannels-1:0]            txOut,
	input logic                              pulseBusy,
	input logic                              fireValid,
	input logic                              fireReady,
	input logic [numChannels*phaseWidth-1:0] firePhase,
	input logic                              instrValid,
	input logic                              instrReady,
	input logic [instrWidth-1:0]             bufInstr
);

	maskedQuiet: assert property (@(posedge txCLK) disable iff (!arstN)
		(txOut & ~chanMask) == '0)
		else $error("txOut high on a masked channel");

	idleQuiet: assert property (@(posedge txCLK) disable iff (!arstN)
		pulseBusy || (txOut == '0))
		else $error("txOut high while the pulse bank is idle");

	fireHold: assert property (@(posedge txCLK) disable iff (!arstN)
		fireValid && !fireReady && !halt |=> fireValid && $stable(firePhase))
		else $error("fire request changed before acceptance");

	instrHold: assert property (@(posedge txCLK) disable iff (!arstN)
		instrValid && !instrReady && !halt |=> $stable(bufInstr))
		else $error("instruction changed while stalled");

endmodule

bind txSequencer txSequencer_assert uAssert (.*);

// ==== sim/txSequencerTb.sv ====
`timescale 1ns/1ps

module txSequencerTb import txPkg::*; ();

	localparam int numTests = 4;
	localparam int maxFires = 256;

	logic txCLK;
	logic arstN;
	logic start;
	logic halt;
	logic [numChannels-1:0] chanMask;
	logic [instrWidth-1:0] instrData;
	logic [numChannels*phaseWidth-1:0] phaseData;
	logic [instrAddrWidth-1:0] instrAddr;
	logic [phaseAddrWidth-1:0] phaseAddr;
	logic [numChannels-1:0] txOut;
	logic [trigWidth-1:0] trigOut;
	logic [ledWidth-1:0] ledOut;
	logic running;

	// external memories, read combinationally
	logic [instrWidth-1:0] progMem [1<<instrAddrWidth];
	logic [numChannels*phaseWidth-1:0] phaseMem [1<<phaseAddrWidth];

	// model state, carried across programs like the DUT registers
	int expTrig[$];
	int expLed[$];
	int expDelay [maxFires][numChannels];
	int expCharge [maxFires];
	int expFires;
	int mTrig = 0;
	int mLed = 0;
	int mCharge = defaultChargeTime;
	int loopCtr [numLoops];

	// observed pulses per channel
	int riseAt [numChannels][maxFires];
	int widthOf [numChannels][maxFires];
	int seen [numChannels];
	int runLen [numChannels];
	int riseTmp [numChannels];
	logic [numChannels-1:0] prevTx;
	logic [trigWidth-1:0] prevTrig;
	logic [ledWidth-1:0] prevLed;

	int cycleCount = 0;
	int cycleLimit = 1000;
	int errors = 0;
	int checks = 0;
	bit checkOn = 0;
	int pc;
	int fireSlot;

	assign instrData = progMem[instrAddr];
	assign phaseData = phaseMem[phaseAddr];

	txSequencer UUT (.*);

	initial
	begin
		txCLK = 1'b0;
		forever #20 txCLK = ~txCLK;
	end

	function automatic logic [instrWidth-1:0] makeInstr(input logic [3:0] op, input int arg,
		input int waitVal);
		makeInstr = {12'b0, op, arg[15:0], waitVal[31:0]};
	endfunction

	task automatic put(input logic [3:0] op, input int arg, input int waitVal);
		progMem[pc] = makeInstr(op, arg, waitVal);
		pc++;
	endtask

	task automatic putFire(input int waitVal);
		int addr;
		addr = fireSlot;
		fireSlot++;
		for (int c = 0; c < numChannels; c++)
			phaseMem[addr][c*phaseWidth +: phaseWidth] = phaseWidth'($urandom % 64);
		put(opFire, addr, waitVal);
	endtask

	task automatic putRandomInstr();
		int choice;
		int w;
		choice = $urandom % 5;
		w = $urandom % 8; // short waits
		case (choice)
			0: put(opSetTrig, ($urandom % 16) << trigLo, w);
			1: put(opSetLeds, ($urandom % 4) << ledLo, w);
			2: put(opSetChargeTime, 1 + $urandom % 40, w);
			3: putFire(w);
			default: put(4'd3, 0, w); // undefined opcode behaves as nop
		endcase
	endtask

	task automatic genProgram(input int testIdx);
		int idx;
		int cnt;
		int body;
		for (int a = 0; a < (1<<instrAddrWidth); a++)
			progMem[a] = makeInstr(opNop, 0, a);
		for (int a = 0; a < (1<<phaseAddrWidth); a++)
			phaseMem[a] = {numChannels{phaseWidth'(a)}};
		pc = 0;
		fireSlot = 0;
		repeat (2 + $urandom % 3) putRandomInstr();
		idx = $urandom % numLoops;
		cnt = 1 + $urandom % 4;
		put(opLoopStart, 0, idx << loopIdxLo);
		body = pc;
		repeat (2 + $urandom % 3) putRandomInstr();
		put(opLoopEnd, body, (idx << loopIdxLo) | cnt);
		if (testIdx == 0)
		begin
			put(opSetChargeTime, 1 + $urandom % 40, 0);
			putFire(0); // back to back, zero wait
			putFire(0);
		end
		repeat (1 + $urandom % 3) putRandomInstr();
		put(opProgramEnd, 0, 0);
	endtask

	// walks the program by the instruction rules, no timing beyond a length estimate
	task automatic runModel();
		int mpc;
		int steps;
		int len;
		int op;
		int arg;
		int w;
		int idx;
		int maxD;
		mpc = 0;
		steps = 0;
		len = 0;
		expFires = 0;
		expTrig.delete();
		expLed.delete();
		while (steps < 10000)
		begin
			op = progMem[mpc][opHi:opLo];
			arg = progMem[mpc][argHi:argLo];
			w = progMem[mpc][waitHi:waitLo];
			idx = (w >> loopIdxLo) & 3;
			steps++;
			len += 4;
			if (op != opLoopStart && op != opLoopEnd)
				len += w; // loop ops carry index and count, not a wait
			mpc++;
			if (op == opProgramEnd)
				break;
			case (op)
				opSetTrig:
				begin
					if (((arg >> trigLo) & 15) != mTrig)
						expTrig.push_back((arg >> trigLo) & 15);
					mTrig = (arg >> trigLo) & 15;
				end
				opSetLeds:
				begin
					if (((arg >> ledLo) & 3) != mLed)
						expLed.push_back((arg >> ledLo) & 3);
					mLed = (arg >> ledLo) & 3;
				end
				opSetChargeTime: mCharge = arg & 9'h1ff;
				opFire:
				begin
					maxD = 0;
					for (int c = 0; c < numChannels; c++)
					begin
						expDelay[expFires][c] = phaseMem[arg & 12'hfff][c*phaseWidth +: phaseWidth];
						if (expDelay[expFires][c] > maxD)
							maxD = expDelay[expFires][c];
					end
					expCharge[expFires] = mCharge;
					expFires++;
					len += 6 + maxD + mCharge;
				end
				opLoopStart: loopCtr[idx] = 1;
				opLoopEnd:
				begin
					if (loopCtr[idx] < (w & 28'hfffffff))
					begin
						loopCtr[idx]++;
						mpc = arg & 13'h1fff;
					end
				end
				default: ;
			endcase
		end
		cycleLimit += 2 * len;
	endtask

	task automatic runProgram(input logic [numChannels-1:0] mask);
		for (int c = 0; c < numChannels; c++)
			seen[c] = 0;
		@(posedge txCLK);
		chanMask <= mask;
		start <= 1'b1;
		@(posedge txCLK);
		start <= 1'b0;
		while (!running)
			@(negedge txCLK);
		while (running)
			@(negedge txCLK);
		repeat (3) @(negedge txCLK);
	endtask

	task automatic checkFires(input logic [numChannels-1:0] mask);
		int base;
		int off;
		int prevEnd;
		int maxD;
		bit countsOk;
		countsOk = 1;
		for (int c = 0; c < numChannels; c++)
		begin
			checks++;
			if (seen[c] != (mask[c] ? expFires : 0))
			begin
				$display("FAIL txOut[%0d] pulse count 0x%0h expected 0x%0h", c, seen[c],
					mask[c] ? expFires : 0);
				errors++;
				countsOk = 0;
			end
		end
		if (!countsOk || mask == '0)
			return;
		prevEnd = -1;
		for (int g = 0; g < expFires; g++)
		begin
			base = -1;
			maxD = 0;
			for (int c = 0; c < numChannels; c++)
			begin
				if (expDelay[g][c] > maxD)
					maxD = expDelay[g][c];
				if (!mask[c])
					continue;
				checks++;
				if (widthOf[c][g] != expCharge[g])
				begin
					$display("FAIL txOut[%0d] width 0x%0h expected 0x%0h", c, widthOf[c][g],
						expCharge[g]);
					errors++;
				end
				off = riseAt[c][g] - expDelay[g][c];
				if (base < 0)
					base = off;
				else if (off != base)
				begin
					$display("FAIL txOut[%0d] rise offset 0x%0h expected 0x%0h", c, off, base);
					errors++;
				end
			end
			checks++;
			if (base < prevEnd)
			begin
				$display("pulse group %0d starts before the previous group ended", g);
				errors++;
			end
			prevEnd = base + maxD + expCharge[g];
		end
	endtask

	task automatic haltTest();
		pc = 0;
		put(opSetTrig, 4'ha << trigLo, 0);
		put(opSetLeds, 2'h3 << ledLo, 0);
		put(opFire, 0, 200);
		put(opSetTrig, 4'h5 << trigLo, 100);
		put(opProgramEnd, 0, 0);
		cycleLimit += 600;
		checkOn = 0;
		@(posedge txCLK);
		start <= 1'b1;
		@(posedge txCLK);
		start <= 1'b0;
		repeat (12 + $urandom % 20) @(posedge txCLK);
		halt <= 1'b1;
		@(posedge txCLK);
		halt <= 1'b0;
		@(negedge txCLK);
		checks++;
		if (txOut != '0 || trigOut != '0 || ledOut != '0 || running)
		begin
			$display("FAIL halt txOut 0x%0h trigOut 0x%0h ledOut 0x%0h running 0x%0h expected 0x0",
				txOut, trigOut, ledOut, running);
			errors++;
		end
		repeat (50)
		begin
			@(negedge txCLK);
			if (running)
			begin
				$display("running rose again after halt without a start");
				errors++;
				break;
			end
		end
	endtask

	// pulse, trigger and LED monitor, sampled away from the driving edge
	always @(negedge txCLK)
	begin
		if (!arstN)
		begin
			prevTx = '0;
			prevTrig = trigOut;
			prevLed = ledOut;
		end
		else
		begin
			cycleCount++;
			for (int c = 0; c < numChannels; c++)
			begin
				if (txOut[c] && !prevTx[c])
				begin
					riseTmp[c] = cycleCount;
					runLen[c] = 1;
				end
				else if (txOut[c])
					runLen[c]++;
				else if (prevTx[c] && seen[c] < maxFires)
				begin
					riseAt[c][seen[c]] = riseTmp[c];
					widthOf[c][seen[c]] = runLen[c];
					seen[c]++;
				end
			end
			prevTx = txOut;
			if (checkOn && trigOut != prevTrig)
			begin
				checks++;
				if (expTrig.size() == 0)
				begin
					$display("trigger output changed when no change was expected");
					errors++;
				end
				else if (trigOut != expTrig[0])
				begin
					$display("FAIL trigOut 0x%0h expected 0x%0h", trigOut, expTrig[0]);
					errors++;
				end
				if (expTrig.size() != 0)
					void'(expTrig.pop_front());
			end
			if (checkOn && ledOut != prevLed)
			begin
				checks++;
				if (expLed.size() == 0)
				begin
					$display("LED output changed when no change was expected");
					errors++;
				end
				else if (ledOut != expLed[0])
				begin
					$display("FAIL ledOut 0x%0h expected 0x%0h", ledOut, expLed[0]);
					errors++;
				end
				if (expLed.size() != 0)
					void'(expLed.pop_front());
			end
			prevTrig = trigOut;
			prevLed = ledOut;
		end
	end

	always @(negedge txCLK)
	begin
		if (cycleCount > cycleLimit)
		begin
			$display("timeout after %0d cycles", cycleCount);
			$display("checks %0d, errors %0d", checks, errors + 1);
			$display("Simulation failed");
			$finish;
		end
	end

	initial
	begin
		logic [numChannels-1:0] mask;
		void'($urandom(6));
		arstN = 1'b0;
		start = 1'b0;
		halt = 1'b0;
		chanMask = '0;
		for (int a = 0; a < (1<<instrAddrWidth); a++)
			progMem[a] = makeInstr(opNop, 0, a);
		for (int a = 0; a < (1<<phaseAddrWidth); a++)
			phaseMem[a] = {numChannels{phaseWidth'(a)}};
		repeat (16) @(posedge txCLK);
		arstN <= 1'b1;
		for (int t = 0; t < numTests; t++)
		begin
			genProgram(t);
			mask = (t == 0) ? '1 : numChannels'($urandom);
			if (mask == '0)
				mask = 8'h01;
			runModel();
			checkOn = 1;
			runProgram(mask);
			checkOn = 0;
			checkFires(mask);
			checks++;
			if (expTrig.size() != 0 || expLed.size() != 0)
			begin
				$display("test %0d ended with trigger or LED changes still missing", t);
				errors++;
			end
		end
		haltTest();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
hw/txPkg.sv
hw/instrFetch.sv
hw/instrExecute.sv
hw/pulseBank.sv
hw/txSequencer.sv
sim/txSequencer_assert.sv
sim/txSequencerTb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the txSequencer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module txSequencerTb -Mdir obj_dir -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -q "Simulation passed" \
	&& exit 0 \
	|| { echo "run.sh: simulation did not pass"; exit 1; }
